// File: design/uart_baud_gen.sv
`timescale 1ns/1ps

module uart_baud_gen
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  uart_regs_pkg::dl_t dl_i,
  input  logic               dl_wr_i,
  output logic               baudout_o
);
  logic [15:0] dl_val;
  logic [15:0] cnt;
  logic        dl_wr_q;
  logic        cnt_zero;

  assign dl_val   = dl_i;
  assign cnt_zero = (cnt == 16'h0000);

  // Wait for the new latch value to land before reloading
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dl_wr_q <= 1'b0;
    else
      dl_wr_q <= dl_wr_i;
  end

  // Down counter with a period of dl cycles
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cnt       <= 16'h0000;
      baudout_o <= 1'b0;
    end
    else
    begin
      if (dl_wr_q || cnt_zero)
        cnt <= dl_val - 16'd1;
      else
        cnt <= cnt - 16'd1;
      // Divisor of zero stops the enable
      baudout_o <= cnt_zero & |dl_val;
    end
  end

  // No enable pulse while the divisor latch holds zero
  a_no_baud_without_dl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    baudout_o |-> dl_val != 16'h0000);

endmodule

// File: design/uart_ctrl_regs.sv
`timescale 1ns/1ps
`include "uart_regs_config.svh"

module uart_ctrl_regs
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  uart_regs_pkg::host_req_t  req_i,
  output uart_regs_pkg::ctrl_view_t view_o,
  output logic                      dl_wr_o,
  output logic                      lsr_read_o,
  output logic                      tx_push_o,
  output logic                      rx_pop_o,
  output logic                      tx_fifo_rst_o,
  output logic                      rx_fifo_rst_o,
  output logic [3:0]                rx_trigger_lvl_o
);
  import uart_regs_pkg::*;

  ier_t       ier;
  fcr_t       fcr;
  lcr_t       lcr;
  logic [7:0] mcr;
  logic [7:0] scr;
  dl_t        dl;
  logic       dlab;
  logic       wr_ier;
  logic       wr_dll;
  logic       wr_dlm;

  // ----------------------------------------------------------------------
  // Address decode, DLAB banks 0 and 1
  // ----------------------------------------------------------------------
  assign dlab   = lcr.dlab;
  assign wr_ier = req_i.we && req_i.adr == `IER_ADR && !dlab;
  assign wr_dll = req_i.we && req_i.adr == `DLL_ADR && dlab;
  assign wr_dlm = req_i.we && req_i.adr == `DLM_ADR && dlab;

  // Same-cycle strobes to the FIFOs
  assign tx_push_o  = req_i.we && req_i.adr == `THR_ADR && !dlab;
  assign rx_pop_o   = req_i.re && req_i.adr == `RBR_ADR && !dlab;
  assign lsr_read_o = req_i.re && req_i.adr == `LSR_ADR;
  assign dl_wr_o    = wr_dll || wr_dlm;

  // ----------------------------------------------------------------------
  // Writable registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ier <= '0;
      lcr <= {3'b000, `EPS_RESET_VALUE, `PEN_RESET_VALUE, `STB_RESET_VALUE, `WLS_RESET_VALUE};
      mcr <= 8'h00;
      scr <= 8'h00;
      dl  <= `DL_RESET_VALUE;
    end
    else
    begin
      if (wr_ier)
        ier <= ier_t'(req_i.d[3:0]);
      if (wr_dll)
        dl.dll <= req_i.d;
      if (wr_dlm)
        dl.dlm <= req_i.d;
      if (req_i.we && req_i.adr == `LCR_ADR)
        lcr <= lcr_t'(req_i.d);
      // upper nibble always reads zero
      if (req_i.we && req_i.adr == `MCR_ADR)
        mcr <= req_i.d & 8'h0F;
      if (req_i.we && req_i.adr == `SCR_ADR)
        scr <= req_i.d;
    end
  end

  // FCR, reset bits drop after one cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      fcr <= '0;
    else if (req_i.we && req_i.adr == `FCR_ADR)
    begin
      fcr.rx_trigger <= req_i.d[7:6];
      fcr.dma_mode   <= req_i.d[3];
      fcr.tx_rst     <= req_i.d[2];
      fcr.rx_rst     <= req_i.d[1];
      fcr.ena        <= req_i.d[0];
    end
    else
    begin
      fcr.tx_rst <= 1'b0;
      fcr.rx_rst <= 1'b0;
    end
  end

  assign tx_fifo_rst_o = fcr.tx_rst;
  assign rx_fifo_rst_o = fcr.rx_rst;

  // Trigger level, zero with FIFOs off
  always_comb
  begin
    case (fcr.rx_trigger)
      2'd0:    rx_trigger_lvl_o = `RX_TRIG_LVL_1;
      2'd1:    rx_trigger_lvl_o = `RX_TRIG_LVL_4;
      2'd2:    rx_trigger_lvl_o = `RX_TRIG_LVL_8;
      default: rx_trigger_lvl_o = `RX_TRIG_LVL_14;
    endcase
    if (!fcr.ena)
      rx_trigger_lvl_o = 4'd0;
  end

  assign view_o = '{
    ier:     ier,
    fcr_ena: fcr.ena,
    lcr:     lcr,
    mcr:     mcr,
    scr:     scr,
    dl:      dl
  };

  // A THR push must leave the divisor latch untouched
  a_push_keeps_dl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_push_o |=> $stable(dl));

endmodule

// File: design/uart_line_event.sv
`timescale 1ns/1ps

module uart_line_event
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic event_i,
  input  logic clear_i,
  output logic flag_o
);
  logic event_q;
  logic event_rise;

  // Edge detect on the raw level
  assign event_rise = event_i & ~event_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      event_q <= 1'b0;
      flag_o  <= 1'b0;
    end
    else
    begin
      event_q <= event_i;
      // New event beats a clear in the same cycle
      flag_o  <= event_rise | (flag_o & ~clear_i);
    end
  end

  // Flag only rises after a 0 to 1 step on the raw input
  a_flag_needs_edge: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(flag_o) |-> $past($rose(event_i)));

endmodule

// File: design/uart_regs_config.svh
`ifndef UART_REGS_CONFIG_SVH
`define UART_REGS_CONFIG_SVH

// ----------------------------------------------------------------------
// Register map, DLAB selects the divisor latch at 0 and 1
// ----------------------------------------------------------------------
`define THR_ADR 3'd0
`define RBR_ADR 3'd0
`define DLL_ADR 3'd0
`define IER_ADR 3'd1
`define DLM_ADR 3'd1
`define FCR_ADR 3'd2
`define LCR_ADR 3'd3
`define MCR_ADR 3'd4
`define LSR_ADR 3'd5
`define MSR_ADR 3'd6
`define SCR_ADR 3'd7

// Reset values
`define DL_RESET_VALUE  16'h0044
`define WLS_RESET_VALUE 2'b00
`define STB_RESET_VALUE 1'b0
`define PEN_RESET_VALUE 1'b0
`define EPS_RESET_VALUE 1'b0

// Sticky LSR error bits, oe pe fe bi
`define LINE_EVENTS 4

// Receive FIFO trigger levels
`define RX_TRIG_LVL_1  4'd1
`define RX_TRIG_LVL_4  4'd4
`define RX_TRIG_LVL_8  4'd8
`define RX_TRIG_LVL_14 4'd14

`endif

// File: design/uart_regs_pkg.sv
package uart_regs_pkg;

  // ----------------------------------------------------------------------
  // Host side
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [2:0] adr;
    logic [7:0] d;
    logic       re;
    logic       we;
  } host_req_t;

  // ----------------------------------------------------------------------
  // Register layouts, MSB first
  // ----------------------------------------------------------------------
  // Upper IER nibble reads zero, so only the low four bits are kept
  typedef struct packed {
    logic edssi;
    logic elsi;
    logic etbei;
    logic erbi;
  } ier_t;

  // Reserved bits 5:4 are not stored
  typedef struct packed {
    logic [1:0] rx_trigger;
    logic       dma_mode;
    logic       tx_rst;
    logic       rx_rst;
    logic       ena;
  } fcr_t;

  typedef struct packed {
    logic       dlab;
    logic       set_break;
    logic       stick_parity;
    logic       eps;
    logic       pen;
    logic       stb;
    logic [1:0] wls;
  } lcr_t;

  typedef struct packed {
    logic rx_fifo_error;
    logic temt;
    logic thre;
    logic bi;
    logic fe;
    logic pe;
    logic oe;
    logic dr;
  } lsr_t;

  // Receive FIFO word, error flags travel with the character
  typedef struct packed {
    logic [7:0] d;
    logic       pe;
    logic       fe;
    logic       bi;
  } rx_d_t;

  // Same order as LSR[4:1]
  typedef struct packed {
    logic bi;
    logic fe;
    logic pe;
    logic oe;
  } line_err_t;

  typedef struct packed {
    logic [7:0] dlm;
    logic [7:0] dll;
  } dl_t;

  // Registered state the readback and irq logic look at
  typedef struct packed {
    ier_t       ier;
    logic       fcr_ena;
    lcr_t       lcr;
    logic [7:0] mcr;
    logic [7:0] scr;
    dl_t        dl;
  } ctrl_view_t;

endpackage

// File: design/uart_regs_top.sv
`timescale 1ns/1ps
`include "uart_regs_config.svh"

module uart_regs_top
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  uart_regs_pkg::host_req_t req_i,
  output logic [7:0]               q_o,
  output logic                     irq_o,
  output logic                     baudout_o,
  input  logic                     tx_empty_i,
  input  logic                     tx_sr_empty_i,
  output logic                     tx_push_o,
  input  logic                     rx_empty_i,
  output logic                     rx_pop_o,
  input  uart_regs_pkg::rx_d_t     rx_q_i,
  input  logic                     overrun_error_i,
  input  logic                     rx_fifo_error_i,
  input  logic                     rx_trigger_i,
  output logic                     tx_fifo_rst_o,
  output logic                     rx_fifo_rst_o,
  output logic [3:0]               rx_trigger_lvl_o
);
  import uart_regs_pkg::*;

  ctrl_view_t view;
  logic       dl_wr;
  logic       lsr_read;
  // Raw event levels and the sticky flags, both in LSR bit order
  line_err_t  line_evt;
  line_err_t  line_err;

  // ----------------------------------------------------------------------
  // Host registers and strobes
  // ----------------------------------------------------------------------
  uart_ctrl_regs u_ctrl_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .view_o           (view),
    .dl_wr_o          (dl_wr),
    .lsr_read_o       (lsr_read),
    .tx_push_o        (tx_push_o),
    .rx_pop_o         (rx_pop_o),
    .tx_fifo_rst_o    (tx_fifo_rst_o),
    .rx_fifo_rst_o    (rx_fifo_rst_o),
    .rx_trigger_lvl_o (rx_trigger_lvl_o)
  );

  // ----------------------------------------------------------------------
  // Sticky line errors, one cell per LSR bit
  // ----------------------------------------------------------------------
  assign line_evt = '{bi: rx_q_i.bi, fe: rx_q_i.fe, pe: rx_q_i.pe, oe: overrun_error_i};

  for (genvar i = 0; i < `LINE_EVENTS; i++)
  begin : g_line_event
    uart_line_event u_line_event (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .event_i (line_evt[i]),
      .clear_i (lsr_read),
      .flag_o  (line_err[i])
    );
  end

  // LSR, interrupt and read data
  uart_status_readback u_status_readback (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .adr_i           (req_i.adr),
    .view_i          (view),
    .line_err_i      (line_err),
    .rx_q_i          (rx_q_i),
    .tx_empty_i      (tx_empty_i),
    .tx_sr_empty_i   (tx_sr_empty_i),
    .rx_empty_i      (rx_empty_i),
    .rx_fifo_error_i (rx_fifo_error_i),
    .rx_trigger_i    (rx_trigger_i),
    .q_o             (q_o),
    .irq_o           (irq_o)
  );

  // 16x baud enable
  uart_baud_gen u_baud_gen (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .dl_i      (view.dl),
    .dl_wr_i   (dl_wr),
    .baudout_o (baudout_o)
  );

endmodule

// File: design/uart_status_readback.sv
`timescale 1ns/1ps
`include "uart_regs_config.svh"

module uart_status_readback
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [2:0]                adr_i,
  input  uart_regs_pkg::ctrl_view_t view_i,
  input  uart_regs_pkg::line_err_t  line_err_i,
  input  uart_regs_pkg::rx_d_t      rx_q_i,
  input  logic                      tx_empty_i,
  input  logic                      tx_sr_empty_i,
  input  logic                      rx_empty_i,
  input  logic                      rx_fifo_error_i,
  input  logic                      rx_trigger_i,
  output logic [7:0]                q_o,
  output logic                      irq_o
);
  import uart_regs_pkg::*;

  logic dr_q;
  logic thre_q;
  logic temt_q;
  logic fifo_err_q;
  lsr_t lsr;
  logic rx_data_irq;

  // ----------------------------------------------------------------------
  // Line Status Register
  // ----------------------------------------------------------------------
  // Live bits, one cycle behind their inputs
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      dr_q       <= 1'b0;
      thre_q     <= 1'b1;
      temt_q     <= 1'b1;
      fifo_err_q <= 1'b0;
    end
    else
    begin
      dr_q       <= ~rx_empty_i;
      thre_q     <= tx_empty_i;
      temt_q     <= tx_empty_i & tx_sr_empty_i;
      // meaningless without FIFOs
      fifo_err_q <= rx_fifo_error_i & view_i.fcr_ena;
    end
  end

  // Sticky error bits come in already registered
  assign lsr = '{
    rx_fifo_error: fifo_err_q,
    temt:          temt_q,
    thre:          thre_q,
    bi:            line_err_i.bi,
    fe:            line_err_i.fe,
    pe:            line_err_i.pe,
    oe:            line_err_i.oe,
    dr:            dr_q
  };

  // ----------------------------------------------------------------------
  // Interrupt
  // ----------------------------------------------------------------------
  // Trigger level in FIFO mode, else any data
  assign rx_data_irq = view_i.fcr_ena ? rx_trigger_i : lsr.dr;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      irq_o <= 1'b0;
    else
      irq_o <= (view_i.ier.elsi  & |line_err_i) |
               (view_i.ier.etbei & lsr.thre)    |
               (view_i.ier.erbi  & rx_data_irq);
  end

  // ----------------------------------------------------------------------
  // Read data
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    case (adr_i)
      `RBR_ADR: q_o <= view_i.lcr.dlab ? view_i.dl.dll : rx_q_i.d;
      `IER_ADR: q_o <= view_i.lcr.dlab ? view_i.dl.dlm : {4'h0, view_i.ier};
      `LCR_ADR: q_o <= view_i.lcr;
      `MCR_ADR: q_o <= view_i.mcr;
      `LSR_ADR: q_o <= lsr;
      `SCR_ADR: q_o <= view_i.scr;
      // No IIR or MSR behind these
      `FCR_ADR,
      `MSR_ADR: q_o <= 8'h00;
      default:  q_o <= 8'h00;
    endcase
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module uart_regs_tb -f uart_regs.f

out=$(./obj_dir/Vuart_regs_tb)
echo "$out"

# Exit status of grep decides the result
echo "$out" | grep -qF '** PASS **'

// File: uart_regs.f
+incdir+design
design/uart_regs_pkg.sv
design/uart_line_event.sv
design/uart_ctrl_regs.sv
design/uart_status_readback.sv
design/uart_baud_gen.sv
design/uart_regs_top.sv
verif/uart_regs_checker.sv
verif/uart_regs_tb.sv

// File: verif/uart_regs_checker.sv
`timescale 1ns/1ps

module uart_regs_checker
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         check_i,
  input  logic [2:0]   kind_i,
  input  logic [159:0] name_i,
  input  logic [7:0]   exp_i,
  input  logic [7:0]   q_i,
  input  logic         irq_i,
  input  logic         baudout_i,
  input  logic         tx_push_i,
  input  logic         rx_pop_i,
  input  logic         tx_fifo_rst_i,
  input  logic         rx_fifo_rst_i,
  input  logic [3:0]   rx_trigger_lvl_i,
  output int           pass_cnt_o,
  output int           fail_cnt_o
);
  // Check kinds, same codes as the testbench table
  localparam logic [2:0] K_Q    = 3'd1;
  localparam logic [2:0] K_IRQ  = 3'd2;
  localparam logic [2:0] K_PUSH = 3'd3;
  localparam logic [2:0] K_POP  = 3'd4;
  localparam logic [2:0] K_FRST = 3'd5;
  localparam logic [2:0] K_LVL  = 3'd6;
  localparam logic [2:0] K_BAUD = 3'd7;

  // High cycles of each strobe since the last check
  logic [7:0]  push_cnt;
  logic [7:0]  pop_cnt;
  logic [7:0]  tx_rst_cnt;
  logic [7:0]  rx_rst_cnt;
  logic [7:0]  push_now;
  logic [7:0]  pop_now;
  logic [7:0]  tx_rst_now;
  logic [7:0]  rx_rst_now;
  // Baud spacing, cycles between the two latest pulses
  logic [15:0] cyc;
  logic [15:0] last_pulse;
  logic [7:0]  gap;
  logic [7:0]  actual;

  // ----------------------------------------------------------------------
  // Sample mid-cycle, away from the driving edge
  // ----------------------------------------------------------------------
  always @(negedge clk_i)
  begin
    if (!rst_ni)
    begin
      push_cnt   = 8'd0;
      pop_cnt    = 8'd0;
      tx_rst_cnt = 8'd0;
      rx_rst_cnt = 8'd0;
      cyc        = 16'd0;
      last_pulse = 16'd0;
      gap        = 8'd0;
      pass_cnt_o = 0;
      fail_cnt_o = 0;
    end
    else
    begin
      cyc = cyc + 16'd1;
      if (baudout_i)
      begin
        gap        = 8'(cyc - last_pulse);
        last_pulse = cyc;
      end
      // Current sample counts too
      push_now   = push_cnt + {7'd0, tx_push_i};
      pop_now    = pop_cnt + {7'd0, rx_pop_i};
      tx_rst_now = tx_rst_cnt + {7'd0, tx_fifo_rst_i};
      rx_rst_now = rx_rst_cnt + {7'd0, rx_fifo_rst_i};
      if (check_i)
      begin
        case (kind_i)
          K_Q:     actual = q_i;
          K_IRQ:   actual = {7'd0, irq_i};
          K_PUSH:  actual = push_now;
          K_POP:   actual = pop_now;
          K_FRST:  actual = {tx_rst_now[3:0], rx_rst_now[3:0]};
          K_LVL:   actual = {4'd0, rx_trigger_lvl_i};
          K_BAUD:  actual = gap;
          default: actual = 8'd0;
        endcase
        if (actual == exp_i)
        begin
          pass_cnt_o = pass_cnt_o + 1;
          $display("ok           %s  exp 0x%02h  act 0x%02h", name_i, exp_i, actual);
        end
        else
        begin
          fail_cnt_o = fail_cnt_o + 1;
          $display("CHECK FAILED %s  exp 0x%02h  act 0x%02h", name_i, exp_i, actual);
        end
        push_cnt   = 8'd0;
        pop_cnt    = 8'd0;
        tx_rst_cnt = 8'd0;
        rx_rst_cnt = 8'd0;
      end
      else
      begin
        push_cnt   = push_now;
        pop_cnt    = pop_now;
        tx_rst_cnt = tx_rst_now;
        rx_rst_cnt = rx_rst_now;
      end
    end
  end

endmodule

// File: verif/uart_regs_tb.sv
`timescale 1ns/1ps
`include "uart_regs_config.svh"

module uart_regs_tb;
  import uart_regs_pkg::*;

  // Row operations
  localparam int OP_IDLE = 0;
  localparam int OP_WR   = 1;
  localparam int OP_RD   = 2;
  localparam int OP_EVT  = 3;
  localparam int OP_LVL  = 4;
  localparam int OP_WAIT = 5;

  // Check kinds, shared codes with uart_regs_checker
  localparam int K_NONE = 0;
  localparam int K_Q    = 1;
  localparam int K_IRQ  = 2;
  localparam int K_PUSH = 3;
  localparam int K_POP  = 4;
  localparam int K_FRST = 5;
  localparam int K_LVL  = 6;
  localparam int K_BAUD = 7;

  logic         clk;
  logic         rst_n;
  host_req_t    req;
  rx_d_t        rx_q;
  logic         tx_empty;
  logic         tx_sr_empty;
  logic         rx_empty;
  logic         overrun_error;
  logic         rx_fifo_error;
  logic         rx_trigger;
  logic [7:0]   q;
  logic         irq;
  logic         baudout;
  logic         tx_push;
  logic         rx_pop;
  logic         tx_fifo_rst;
  logic         rx_fifo_rst;
  logic [3:0]   rx_trigger_lvl;

  // Request to the checker
  logic         check;
  logic [2:0]   check_kind;
  logic [159:0] check_name;
  logic [7:0]   check_exp;
  int           pass_cnt;
  int           fail_cnt;

  // Stimulus table, one entry per row in each queue
  logic [159:0] t_name[$];
  int           t_op[$];
  logic [2:0]   t_adr[$];
  logic [7:0]   t_data[$];
  int           t_kind[$];
  logic [7:0]   t_exp[$];

  logic [7:0]   scr_a;
  logic [7:0]   scr_b;
  int           n_checks;
  int           cycles = 0;
  int           cycle_limit = 0;

  always #50 clk = ~clk;

  uart_regs_top dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .req_i            (req),
    .q_o              (q),
    .irq_o            (irq),
    .baudout_o        (baudout),
    .tx_empty_i       (tx_empty),
    .tx_sr_empty_i    (tx_sr_empty),
    .tx_push_o        (tx_push),
    .rx_empty_i       (rx_empty),
    .rx_pop_o         (rx_pop),
    .rx_q_i           (rx_q),
    .overrun_error_i  (overrun_error),
    .rx_fifo_error_i  (rx_fifo_error),
    .rx_trigger_i     (rx_trigger),
    .tx_fifo_rst_o    (tx_fifo_rst),
    .rx_fifo_rst_o    (rx_fifo_rst),
    .rx_trigger_lvl_o (rx_trigger_lvl)
  );

  uart_regs_checker u_checker (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .check_i          (check),
    .kind_i           (check_kind),
    .name_i           (check_name),
    .exp_i            (check_exp),
    .q_i              (q),
    .irq_i            (irq),
    .baudout_i        (baudout),
    .tx_push_i        (tx_push),
    .rx_pop_i         (rx_pop),
    .tx_fifo_rst_i    (tx_fifo_rst),
    .rx_fifo_rst_i    (rx_fifo_rst),
    .rx_trigger_lvl_i (rx_trigger_lvl),
    .pass_cnt_o       (pass_cnt),
    .fail_cnt_o       (fail_cnt)
  );

  task automatic add_row(input logic [159:0] name, input int op, input logic [2:0] adr,
                         input logic [7:0] data, input int kind, input logic [7:0] exp);
    t_name.push_back(name);
    t_op.push_back(op);
    t_adr.push_back(adr);
    t_data.push_back(data);
    t_kind.push_back(kind);
    t_exp.push_back(exp);
    if (kind != K_NONE)
      n_checks = n_checks + 1;
  endtask

  // ----------------------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------------------
  task automatic build_table();
    // Reset values
    add_row("lcr_reset", OP_RD, `LCR_ADR, 8'h00, K_Q, 8'h00);
    add_row("lsr_reset", OP_RD, `LSR_ADR, 8'h00, K_Q, 8'h60);
    add_row("", OP_WR, `LCR_ADR, 8'h80, K_NONE, 8'h00);
    add_row("dll_reset", OP_RD, `DLL_ADR, 8'h00, K_Q, 8'h44);
    add_row("dlm_reset", OP_RD, `DLM_ADR, 8'h00, K_Q, 8'h00);
    add_row("", OP_WR, `LCR_ADR, 8'h00, K_NONE, 8'h00);
    // Masking and scratch
    add_row("", OP_WR, `IER_ADR, 8'hFF, K_NONE, 8'h00);
    add_row("ier_mask", OP_RD, `IER_ADR, 8'h00, K_Q, 8'h0F);
    add_row("", OP_WR, `IER_ADR, 8'h00, K_NONE, 8'h00);
    add_row("", OP_WR, `MCR_ADR, 8'hFF, K_NONE, 8'h00);
    add_row("mcr_mask", OP_RD, `MCR_ADR, 8'h00, K_Q, 8'h0F);
    add_row("", OP_WR, `SCR_ADR, scr_a, K_NONE, 8'h00);
    add_row("scr_rand_a", OP_RD, `SCR_ADR, 8'h00, K_Q, scr_a);
    add_row("", OP_WR, `SCR_ADR, scr_b, K_NONE, 8'h00);
    add_row("scr_rand_b", OP_RD, `SCR_ADR, 8'h00, K_Q, scr_b);
    // DLAB banking of address 0
    add_row("", OP_WR, `LCR_ADR, 8'h80, K_NONE, 8'h00);
    add_row("dll_wr_no_push", OP_WR, `DLL_ADR, 8'h5A, K_PUSH, 8'h00);
    add_row("dll_banked", OP_RD, `DLL_ADR, 8'h00, K_Q, 8'h5A);
    add_row("", OP_WR, `LCR_ADR, 8'h03, K_NONE, 8'h00);
    add_row("thr_push", OP_WR, `THR_ADR, 8'h5A, K_PUSH, 8'h01);
    add_row("lcr_readback", OP_RD, `LCR_ADR, 8'h00, K_Q, 8'h03);
    // FCR trigger field, enable in bit 0
    add_row("trig_lvl_1", OP_WR, `FCR_ADR, 8'h01, K_LVL, 8'd1);
    add_row("trig_lvl_4", OP_WR, `FCR_ADR, 8'h41, K_LVL, 8'd4);
    add_row("trig_lvl_8", OP_WR, `FCR_ADR, 8'h81, K_LVL, 8'd8);
    add_row("trig_lvl_14", OP_WR, `FCR_ADR, 8'hC1, K_LVL, 8'd14);
    add_row("trig_fifo_off", OP_WR, `FCR_ADR, 8'hC0, K_LVL, 8'd0);
    add_row("", OP_WR, `FCR_ADR, 8'h07, K_NONE, 8'h00);
    // One high cycle on each reset, packed tx then rx
    add_row("fifo_rst_pulse", OP_IDLE, 3'd0, 8'h00, K_FRST, 8'h11);
    add_row("fcr_reads_zero", OP_RD, `FCR_ADR, 8'h00, K_Q, 8'h00);
    // Sticky errors, event bits in LSR order oe pe fe bi
    add_row("", OP_EVT, 3'd0, 8'h02, K_NONE, 8'h00);
    add_row("lsr_pe_set", OP_RD, `LSR_ADR, 8'h00, K_Q, 8'h64);
    add_row("lsr_pe_cleared", OP_RD, `LSR_ADR, 8'h00, K_Q, 8'h60);
    add_row("", OP_EVT, 3'd0, 8'h01, K_NONE, 8'h00);
    add_row("", OP_WR, `IER_ADR, 8'h04, K_NONE, 8'h00);
    add_row("irq_line_err", OP_IDLE, 3'd0, 8'h00, K_IRQ, 8'h01);
    add_row("lsr_oe_set", OP_RD, `LSR_ADR, 8'h00, K_Q, 8'h62);
    add_row("irq_line_cleared", OP_IDLE, 3'd0, 8'h00, K_IRQ, 8'h00);
    // THR and receive data interrupts, level bits rx_empty then rx_trigger
    add_row("", OP_WR, `IER_ADR, 8'h02, K_NONE, 8'h00);
    add_row("irq_thre", OP_IDLE, 3'd0, 8'h00, K_IRQ, 8'h01);
    add_row("", OP_WR, `FCR_ADR, 8'h00, K_NONE, 8'h00);
    add_row("", OP_WR, `IER_ADR, 8'h01, K_NONE, 8'h00);
    add_row("irq_rx_idle", OP_IDLE, 3'd0, 8'h00, K_IRQ, 8'h00);
    add_row("", OP_LVL, 3'd0, 8'h00, K_NONE, 8'h00);
    add_row("irq_rx_data", OP_IDLE, 3'd0, 8'h00, K_IRQ, 8'h01);
    add_row("", OP_WR, `FCR_ADR, 8'h01, K_NONE, 8'h00);
    add_row("irq_fifo_no_trig", OP_IDLE, 3'd0, 8'h00, K_IRQ, 8'h00);
    add_row("", OP_LVL, 3'd0, 8'h02, K_NONE, 8'h00);
    add_row("irq_fifo_trig", OP_IDLE, 3'd0, 8'h00, K_IRQ, 8'h01);
    add_row("rbr_data", OP_RD, `RBR_ADR, 8'h00, K_Q, 8'hA5);
    add_row("rbr_pop", OP_RD, `RBR_ADR, 8'h00, K_POP, 8'h01);
    add_row("", OP_LVL, 3'd0, 8'h01, K_NONE, 8'h00);
    add_row("", OP_WR, `IER_ADR, 8'h00, K_NONE, 8'h00);
    add_row("irq_all_off", OP_IDLE, 3'd0, 8'h00, K_IRQ, 8'h00);
    // Baud spacing after settling
    add_row("", OP_WR, `LCR_ADR, 8'h80, K_NONE, 8'h00);
    add_row("", OP_WR, `DLM_ADR, 8'h00, K_NONE, 8'h00);
    add_row("", OP_WR, `DLL_ADR, 8'h04, K_NONE, 8'h00);
    add_row("baud_div_4", OP_WAIT, 3'd0, 8'd24, K_BAUD, 8'd4);
    add_row("", OP_WR, `DLL_ADR, 8'h07, K_NONE, 8'h00);
    add_row("baud_div_7", OP_WAIT, 3'd0, 8'd30, K_BAUD, 8'd7);
    add_row("", OP_WR, `LCR_ADR, 8'h00, K_NONE, 8'h00);
    add_row("dlab_cleared", OP_RD, `LCR_ADR, 8'h00, K_Q, 8'h00);
  endtask

  // Drive one cycle, then hand the expected value to the checker
  task automatic apply_row(input int i);
    @(posedge clk);
    #1;
    case (t_op[i])
      OP_WR:
      begin
        req.adr = t_adr[i];
        req.d   = t_data[i];
        req.we  = 1'b1;
      end
      OP_RD:
      begin
        req.adr = t_adr[i];
        req.re  = 1'b1;
      end
      OP_EVT:
      begin
        overrun_error = t_data[i][0];
        rx_q.pe       = t_data[i][1];
        rx_q.fe       = t_data[i][2];
        rx_q.bi       = t_data[i][3];
      end
      OP_LVL:
      begin
        rx_empty   = t_data[i][0];
        rx_trigger = t_data[i][1];
      end
      default:
      begin
      end
    endcase
    @(posedge clk);
    #1;
    req           = '0;
    overrun_error = 1'b0;
    rx_q.pe       = 1'b0;
    rx_q.fe       = 1'b0;
    rx_q.bi       = 1'b0;
    if (t_op[i] == OP_WAIT)
    begin
      repeat (t_data[i]) @(posedge clk);
      #1;
    end
    check_name = t_name[i];
    check_kind = 3'(t_kind[i]);
    check_exp  = t_exp[i];
    check      = (t_kind[i] != K_NONE);
    @(negedge clk);
    #1;
    check = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Run control
  // ----------------------------------------------------------------------
  initial
  begin
    void'($urandom(40723));
    clk           = 1'b0;
    rst_n         = 1'b0;
    req           = '0;
    rx_q          = '0;
    rx_q.d        = 8'hA5;
    tx_empty      = 1'b1;
    tx_sr_empty   = 1'b1;
    rx_empty      = 1'b1;
    overrun_error = 1'b0;
    rx_fifo_error = 1'b0;
    rx_trigger    = 1'b0;
    check         = 1'b0;
    check_kind    = 3'd0;
    check_name    = '0;
    check_exp     = 8'h00;
    n_checks      = 0;
    scr_a         = 8'($urandom());
    scr_b         = 8'($urandom());
    build_table();
    cycle_limit = t_op.size() * 4 + 200;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < t_op.size(); i++)
      apply_row(i);
    @(posedge clk);
    #1;
    if (pass_cnt + fail_cnt != n_checks)
      $display("Only %0d of %0d checks were made", pass_cnt + fail_cnt, n_checks);
    $display("Checks %0d, passed %0d, failed %0d", n_checks, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == n_checks)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // Hard stop if a row never completes
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
    begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule
